// ==== logic/biu_write_pkg.sv ====
// Write channel package with bus widths, index field and packed channel payloads
package biu_write_pkg;

  // ==========================================================
  // Widths
  // ==========================================================
  localparam int paddr_w   = 40;
  localparam int axi_id_w  = 8;
  localparam int axi_len_w = 8;
  localparam int data_w    = 128;
  localparam int strb_w    = 16;

  // Address bits compared by each write table entry
  localparam int idx_lsb = 4;
  localparam int idx_msb = 13;
  localparam int idx_w   = idx_msb - idx_lsb + 1;

  // ==========================================================
  // Payload types
  // ==========================================================
  // Core-side write request, short length field
  typedef struct packed {
    logic [paddr_w-1:0] addr;
    logic [2:0]         size;
    logic [1:0]         len;
    logic [1:0]         burst;
    logic [3:0]         cache;
    logic [2:0]         prot;
    logic               lock;
  } aw_req_t;

  // Pad-side address with full AXI length and ID
  typedef struct packed {
    logic [paddr_w-1:0]   addr;
    logic [2:0]           size;
    logic [axi_len_w-1:0] len;
    logic [1:0]           burst;
    logic [3:0]           cache;
    logic [2:0]           prot;
    logic                 lock;
    logic [axi_id_w-1:0]  id;
  } aw_pad_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } w_beat_t;

endpackage

// ==== logic/biu_skid_reg.sv ====
// One-entry valid/ready buffer between a core channel and its pad side
`timescale 1ns/1ps

module biu_skid_reg #(
  parameter type payload_t = logic
) (
  input  logic     biu_clk,
  input  logic     cpurst_b,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic buf_vld;
  logic accept;
  logic drain;

  // Room when empty, or when the held item leaves this cycle
  assign in_ready = !buf_vld || out_ready;
  assign accept   = in_valid && in_ready;
  assign drain    = buf_vld && out_ready;

  always_ff @(posedge biu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      buf_vld <= 1'b0;
    else if (accept)
      buf_vld <= 1'b1;
    else if (drain)
      buf_vld <= 1'b0;
  end

  always_ff @(posedge biu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      out_data <= '0;
    else if (accept)
      out_data <= in_data;
  end

  assign out_valid = buf_vld;

endmodule

// ==== logic/biu_wt_entry.sv ====
// Single outstanding-write record with index and ordering hazard compares
`timescale 1ns/1ps

module biu_wt_entry (
  input  logic                            biu_clk,
  input  logic                            cpurst_b,
  input  logic                            create_en,
  input  logic [biu_write_pkg::idx_w-1:0] create_idx,
  input  logic                            create_so,
  input  logic                            release_en,
  input  logic [biu_write_pkg::idx_w-1:0] ar_idx,
  input  logic                            ar_so,
  input  logic [biu_write_pkg::idx_w-1:0] aw_idx,
  input  logic                            aw_so,
  output logic                            entry_vld,
  output logic                            ar_hit,
  output logic                            aw_hit
);

  logic [biu_write_pkg::idx_w-1:0] entry_idx;
  logic                            entry_so;

  // ==========================================================
  // Entry state
  // ==========================================================
  // Create wins over a release aimed at the same slot
  always_ff @(posedge biu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (create_en)
      entry_vld <= 1'b1;
    else if (release_en)
      entry_vld <= 1'b0;
  end

  always_ff @(posedge biu_clk)
  begin
    if (create_en)
    begin
      entry_idx <= create_idx;
      entry_so  <= create_so;
    end
  end

  // ==========================================================
  // Hazard compares
  // ==========================================================
  // Same index bits, or strongly ordered on both sides
  assign ar_hit = entry_vld && ((entry_idx == ar_idx) || (entry_so && ar_so));
  assign aw_hit = entry_vld && ((entry_idx == aw_idx) || (entry_so && aw_so));

endmodule

// ==== logic/biu_write_table.sv ====
// Outstanding write table with rotating create pointer and B-driven release
`timescale 1ns/1ps

module biu_write_table #(
  parameter int wt_depth = 16
) (
  input  logic                                biu_clk,
  input  logic                                cpurst_b,
  input  logic                                create_en,
  input  biu_write_pkg::aw_req_t              create_req,
  output logic [biu_write_pkg::axi_id_w-1:0]  create_id,
  input  logic [biu_write_pkg::paddr_w-1:0]   ar_addr,
  input  logic [3:0]                          ar_cache,
  input  logic                                b_valid,
  input  logic [biu_write_pkg::axi_id_w-1:0]  b_id,
  output logic                                full,
  output logic                                ar_hazard,
  output logic                                aw_hazard,
  output logic                                idle
);

  localparam int ptr_w = $clog2(wt_depth);

  logic [ptr_w-1:0]                create_ptr;
  logic                            rel_vld;
  logic [ptr_w-1:0]                rel_id;
  logic [wt_depth-1:0]             entry_vld;
  logic [wt_depth-1:0]             ar_hit;
  logic [wt_depth-1:0]             aw_hit;
  logic [biu_write_pkg::idx_w-1:0] ar_idx;
  logic [biu_write_pkg::idx_w-1:0] aw_idx;
  logic                            ar_so;
  logic                            aw_so;

  // ==========================================================
  // Create pointer
  // ==========================================================
  always_ff @(posedge biu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      create_ptr <= '0;
    else if (create_en)
      create_ptr <= create_ptr + 1'b1;
  end

  assign create_id = biu_write_pkg::axi_id_w'(create_ptr);

  // Next slot still busy
  assign full = entry_vld[create_ptr];

  // ==========================================================
  // B release register
  // ==========================================================
  // One cycle between the response and the entry clearing
  always_ff @(posedge biu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rel_vld <= 1'b0;
      rel_id  <= '0;
    end
    else
    begin
      rel_vld <= b_valid;
      if (b_valid)
        rel_id <= b_id[ptr_w-1:0];
    end
  end

  // Compare fields; cache bit 1 clear marks strongly ordered
  assign ar_idx = ar_addr[biu_write_pkg::idx_msb:biu_write_pkg::idx_lsb];
  assign aw_idx = create_req.addr[biu_write_pkg::idx_msb:biu_write_pkg::idx_lsb];
  assign ar_so  = !ar_cache[1];
  assign aw_so  = !create_req.cache[1];

  // ==========================================================
  // Entry array
  // ==========================================================
  for (genvar i = 0; i < wt_depth; i++)
  begin : g_entry
    biu_wt_entry u_entry (
      .biu_clk    (biu_clk),
      .cpurst_b   (cpurst_b),
      .create_en  (create_en && (create_ptr == ptr_w'(i))),
      .create_idx (aw_idx),
      .create_so  (aw_so),
      .release_en (rel_vld && (rel_id == ptr_w'(i))),
      .ar_idx     (ar_idx),
      .ar_so      (ar_so),
      .aw_idx     (aw_idx),
      .aw_so      (aw_so),
      .entry_vld  (entry_vld[i]),
      .ar_hit     (ar_hit[i]),
      .aw_hit     (aw_hit[i])
    );
  end

  assign ar_hazard = |ar_hit;
  assign aw_hazard = |aw_hit;
  assign idle      = ~|entry_vld;

endmodule

// ==== logic/biu_write_channel.sv ====
// AXI write side of the bus interface unit joining AW, W and B with the write table
`timescale 1ns/1ps

module biu_write_channel #(
  parameter int wt_depth = 16
) (
  input  logic                                biu_clk,
  input  logic                                cpurst_b,
  // Core AW
  input  logic                                aw_valid,
  input  biu_write_pkg::aw_req_t              aw_req,
  output logic                                aw_ready,
  // Core W
  input  logic                                w_valid,
  input  biu_write_pkg::w_beat_t              w_beat,
  output logic                                w_ready,
  // Incoming read for hazard check
  input  logic [biu_write_pkg::paddr_w-1:0]   ar_addr,
  input  logic [3:0]                          ar_cache,
  // Pad AW
  output logic                                pad_aw_valid,
  output biu_write_pkg::aw_pad_t              pad_aw,
  input  logic                                pad_aw_ready,
  // Pad W
  output logic                                pad_w_valid,
  output biu_write_pkg::w_beat_t              pad_w,
  input  logic                                pad_w_ready,
  // Pad B
  input  logic                                pad_b_valid,
  input  logic [biu_write_pkg::axi_id_w-1:0]  pad_b_id,
  input  logic [1:0]                          pad_b_resp,
  output logic                                pad_b_ready,
  // Table status
  output logic                                ar_hazard,
  output logic                                aw_hazard,
  output logic                                wt_idle
);

  biu_write_pkg::aw_pad_t                aw_pad_in;
  logic [biu_write_pkg::axi_id_w-1:0]    create_id;
  logic                                  wt_full;
  logic                                  aw_buf_ready;
  logic                                  aw_create_en;

  // ==========================================================
  // AW channel
  // ==========================================================
  // No new write while the slot under the pointer is in use
  assign aw_ready     = aw_buf_ready && !wt_full;
  assign aw_create_en = aw_valid && aw_ready;

  // Pad form of the request, tagged with the table slot
  always_comb
  begin
    aw_pad_in.addr  = aw_req.addr;
    aw_pad_in.size  = aw_req.size;
    aw_pad_in.len   = biu_write_pkg::axi_len_w'(aw_req.len);
    aw_pad_in.burst = aw_req.burst;
    aw_pad_in.cache = aw_req.cache;
    aw_pad_in.prot  = aw_req.prot;
    aw_pad_in.lock  = aw_req.lock;
    aw_pad_in.id    = create_id;
  end

  biu_skid_reg #(
    .payload_t (biu_write_pkg::aw_pad_t)
  ) u_aw_buf (
    .biu_clk   (biu_clk),
    .cpurst_b  (cpurst_b),
    .in_valid  (aw_valid && !wt_full),
    .in_data   (aw_pad_in),
    .in_ready  (aw_buf_ready),
    .out_valid (pad_aw_valid),
    .out_data  (pad_aw),
    .out_ready (pad_aw_ready)
  );

  // ==========================================================
  // W channel
  // ==========================================================
  biu_skid_reg #(
    .payload_t (biu_write_pkg::w_beat_t)
  ) u_w_buf (
    .biu_clk   (biu_clk),
    .cpurst_b  (cpurst_b),
    .in_valid  (w_valid),
    .in_data   (w_beat),
    .in_ready  (w_ready),
    .out_valid (pad_w_valid),
    .out_data  (pad_w),
    .out_ready (pad_w_ready)
  );

  // ==========================================================
  // B channel and write table
  // ==========================================================
  // Always ready; pad_b_resp carries no action here
  assign pad_b_ready = 1'b1;

  biu_write_table #(
    .wt_depth (wt_depth)
  ) u_write_table (
    .biu_clk    (biu_clk),
    .cpurst_b   (cpurst_b),
    .create_en  (aw_create_en),
    .create_req (aw_req),
    .create_id  (create_id),
    .ar_addr    (ar_addr),
    .ar_cache   (ar_cache),
    .b_valid    (pad_b_valid),
    .b_id       (pad_b_id),
    .full       (wt_full),
    .ar_hazard  (ar_hazard),
    .aw_hazard  (aw_hazard),
    .idle       (wt_idle)
  );

endmodule

// ==== include/biu_write_tb_tasks.svh ====
// Testbench tasks driving core AW requests, W beats, pad B responses and idle waits

function automatic logic [biu_write_pkg::paddr_w-1:0] rand_addr();
  return {8'($urandom), $urandom};
endfunction

// Size, len, burst, prot and lock random; holds valid until aw_ready
task automatic send_aw(input logic [biu_write_pkg::paddr_w-1:0] addr, input logic [3:0] cache);
  aw_req   = {addr, 7'($urandom), cache, 4'($urandom)};
  aw_valid = 1'b1;
  #1;
  while (!aw_ready)
  begin
    @(posedge biu_clk);
    #11;
  end
  @(posedge biu_clk);
  #10;
  aw_valid = 1'b0;
endtask

task automatic send_w();
  w_beat  = {$urandom, $urandom, $urandom, $urandom, 16'($urandom), 1'($urandom)};
  w_valid = 1'b1;
  #1;
  while (!w_ready)
  begin
    @(posedge biu_clk);
    #11;
  end
  @(posedge biu_clk);
  #10;
  w_valid = 1'b0;
endtask

// Response code random, the DUT ignores it
task automatic send_b(input int id);
  pad_b_valid = 1'b1;
  pad_b_id    = biu_write_pkg::axi_id_w'(id);
  pad_b_resp  = 2'($urandom);
  @(posedge biu_clk);
  #10;
  pad_b_valid = 1'b0;
endtask

task automatic wait_idle();
  #1;
  while (!wt_idle)
  begin
    @(posedge biu_clk);
    #11;
  end
  @(posedge biu_clk);
  #10;
endtask

// ==== tb/biu_write_channel_tb.sv ====
// Testbench for the BIU write channel with a reference write table and concurrent checks
`timescale 1ns/1ps

module biu_write_channel_tb;

  localparam int wt_depth  = 16;
  localparam int ptr_w     = $clog2(wt_depth);
  localparam int num_tests = 6;

  logic                              biu_clk;
  logic                              cpurst_b     = 1'b0;
  logic                              aw_valid     = 1'b0;
  logic                              w_valid      = 1'b0;
  logic                              pad_aw_ready = 1'b1;
  logic                              pad_w_ready  = 1'b1;
  logic                              pad_b_valid  = 1'b0;
  logic [biu_write_pkg::axi_id_w-1:0] pad_b_id    = '0;
  logic [1:0]                        pad_b_resp   = '0;
  logic [biu_write_pkg::paddr_w-1:0] ar_addr      = '0;
  logic [3:0]                        ar_cache     = 4'hf;
  biu_write_pkg::aw_req_t            aw_req       = '0;
  biu_write_pkg::w_beat_t            w_beat       = '0;
  logic                              aw_ready;
  logic                              w_ready;
  logic                              pad_aw_valid;
  logic                              pad_w_valid;
  logic                              pad_b_ready;
  logic                              ar_hazard;
  logic                              aw_hazard;
  logic                              wt_idle;
  biu_write_pkg::aw_pad_t            pad_aw;
  biu_write_pkg::aw_pad_t            exp_pad_aw;
  biu_write_pkg::w_beat_t            pad_w;

  // Reference table state
  logic [wt_depth-1:0]               exp_vld;
  logic [wt_depth-1:0]               exp_so;
  logic [biu_write_pkg::idx_w-1:0]   exp_idx [wt_depth];
  logic [ptr_w-1:0]                  exp_ptr;
  logic [ptr_w-1:0]                  rel_id;
  logic                              rel_pend;
  logic                              exp_aw_buf;
  logic                              exp_w_buf;
  logic                              exp_ar_haz;
  logic                              exp_aw_haz;
  logic [biu_write_pkg::paddr_w-1:0] fill_addr [wt_depth];
  int                                errors = 0;

  initial
  begin
    biu_clk = 1'b0;
    forever #50 biu_clk = ~biu_clk;
  end

  biu_write_channel #(.wt_depth(wt_depth)) dut (.*);

  `include "biu_write_tb_tasks.svh"

  // ==========================================================
  // Reference model
  // ==========================================================
  // B seen at one edge frees its entry at the next; a create on that edge wins
  always @(posedge biu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      exp_vld    <= '0;
      exp_ptr    <= '0;
      rel_pend   <= 1'b0;
      rel_id     <= '0;
      exp_aw_buf <= 1'b0;
      exp_w_buf  <= 1'b0;
    end
    else
    begin
      rel_pend <= pad_b_valid;
      if (pad_b_valid)
        rel_id <= pad_b_id[ptr_w-1:0];
      if (rel_pend)
        exp_vld[rel_id] <= 1'b0;
      if (aw_valid && aw_ready)
      begin
        exp_vld[exp_ptr] <= 1'b1;
        exp_idx[exp_ptr] <= aw_req.addr[13:4];
        exp_so[exp_ptr]  <= !aw_req.cache[1];
        exp_ptr          <= exp_ptr + 1'b1;
      end
      // Pad buffers fill on a core transfer and empty on a pad transfer
      if (aw_valid && aw_ready)
        exp_aw_buf <= 1'b1;
      else if (pad_aw_ready)
        exp_aw_buf <= 1'b0;
      if (w_valid && w_ready)
        exp_w_buf <= 1'b1;
      else if (pad_w_ready)
        exp_w_buf <= 1'b0;
    end
  end

  // Pad address expected for the request now on the core side
  always_comb
  begin
    exp_pad_aw.addr  = aw_req.addr;
    exp_pad_aw.size  = aw_req.size;
    exp_pad_aw.len   = biu_write_pkg::axi_len_w'(aw_req.len);
    exp_pad_aw.burst = aw_req.burst;
    exp_pad_aw.cache = aw_req.cache;
    exp_pad_aw.prot  = aw_req.prot;
    exp_pad_aw.lock  = aw_req.lock;
    exp_pad_aw.id    = biu_write_pkg::axi_id_w'(exp_ptr);
  end

  always_comb
  begin
    exp_ar_haz = 1'b0;
    exp_aw_haz = 1'b0;
    for (int i = 0; i < wt_depth; i++)
    begin
      if (exp_vld[i])
      begin
        exp_ar_haz = exp_ar_haz || (exp_idx[i] == ar_addr[13:4]) || (exp_so[i] && !ar_cache[1]);
        exp_aw_haz = exp_aw_haz || (exp_idx[i] == aw_req.addr[13:4]) ||
                     (exp_so[i] && !aw_req.cache[1]);
      end
    end
  end

  // ==========================================================
  // Checks
  // ==========================================================
  task automatic record_failure(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  assert property (@(posedge biu_clk) $rose(cpurst_b) |->
                   !pad_aw_valid && !pad_w_valid && wt_idle && aw_ready && w_ready)
    else record_failure("outputs wrong after reset");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   aw_valid && aw_ready |=> pad_aw_valid && pad_aw == $past(exp_pad_aw))
    else record_failure("pad AW does not match the accepted request");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   w_valid && w_ready |=> pad_w_valid && pad_w == $past(w_beat))
    else record_failure("pad W does not match the accepted beat");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   pad_aw_valid && !pad_aw_ready |=> pad_aw_valid && $stable(pad_aw))
    else record_failure("pad AW changed while stalled");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   pad_w_valid && !pad_w_ready |=> pad_w_valid && $stable(pad_w))
    else record_failure("pad W changed while stalled");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   pad_aw_valid == exp_aw_buf && pad_w_valid == exp_w_buf)
    else record_failure("pad valid disagrees with buffer occupancy");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   aw_ready == (!exp_vld[exp_ptr] && (!exp_aw_buf || pad_aw_ready)))
    else record_failure("aw_ready disagrees with buffer and table state");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   w_ready == (!exp_w_buf || pad_w_ready))
    else record_failure("w_ready disagrees with buffer state");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   ar_hazard == exp_ar_haz && aw_hazard == exp_aw_haz)
    else record_failure("hazard flag wrong");
  assert property (@(posedge biu_clk) disable iff (!cpurst_b)
                   wt_idle == (exp_vld == '0) && pad_b_ready)
    else record_failure("wt_idle or pad_b_ready wrong");

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial
  begin
    void'($urandom(32'h0cf3_7f44));
    repeat (16) @(posedge biu_clk);
    #10;
    cpurst_b = 1'b1;
    ar_addr  = rand_addr();
    ar_cache = 4'($urandom);
    // Streaming traffic with the pad always ready
    fork
      for (int i = 0; i < 8; i++)
        send_aw(rand_addr(), 4'($urandom));
      for (int i = 0; i < 8; i++)
        send_w();
    join
    for (int i = 0; i < 8; i++)
      send_b(i);
    wait_idle();
    // Pad back-pressure on both channels
    pad_aw_ready = 1'b0;
    pad_w_ready  = 1'b0;
    fork
      for (int i = 0; i < 8; i++)
        send_aw(rand_addr(), 4'hf);
      for (int i = 0; i < 8; i++)
        send_w();
      begin
        repeat (6)
        begin
          repeat (3) @(posedge biu_clk);
          #10;
          pad_aw_ready = !pad_aw_ready;
          pad_w_ready  = 1'($urandom);
        end
        pad_aw_ready = 1'b1;
        pad_w_ready  = 1'b1;
      end
    join
    for (int i = 8; i < 16; i++)
      send_b(i);
    wait_idle();
    // Fill the table with the last entry strongly ordered
    for (int i = 0; i < wt_depth; i++)
    begin
      fill_addr[i] = rand_addr();
      send_aw(fill_addr[i], (i == wt_depth - 1) ? 4'h0 : 4'hf);
    end
    fork
      send_aw(rand_addr(), 4'hf);
      begin
        repeat (3) @(posedge biu_clk);
        #10;
        send_b(0);
      end
    join
    // Read hazard by index, then by ordering, then write hazard
    ar_cache = 4'hf;
    ar_addr  = fill_addr[5];
    repeat (2) @(posedge biu_clk);
    #10;
    ar_addr = rand_addr();
    repeat (2) @(posedge biu_clk);
    #10;
    ar_cache     = 4'h0;
    aw_req.cache = 4'h0;
    repeat (2) @(posedge biu_clk);
    #10;
    for (int i = 1; i <= wt_depth; i++)
      send_b(i % wt_depth);
    wait_idle();
    $display("Checks complete with %0d errors", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    repeat (num_tests * 200 + 1000) @(posedge biu_clk);
    $display("Watchdog expired before the test sequence completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
logic/biu_write_pkg.sv
logic/biu_skid_reg.sv
logic/biu_wt_entry.sv
logic/biu_write_table.sv
logic/biu_write_channel.sv
tb/biu_write_channel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= biu_write_channel_tb
RTL_TOP   ?= biu_write_channel
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
